/* logic/uart_defines.svh */
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// main clock in MHz, must be a multiple of 10
`define UART_CLK_MHZ 20

// samples taken per bit period
`define UART_OVERSAMPLE 8

// width of the baud divider field in the configuration
`define UART_BAUD_DIV_W 8

`endif

/* logic/uart_pkg.sv */
`default_nettype none
`include "uart_defines.svh"

package uart_pkg;

	typedef enum logic [1:0] {
		DATA_8 = 2'd0,
		DATA_7 = 2'd1,
		DATA_6 = 2'd2,
		DATA_5 = 2'd3
	} uart_data_bits_e;

	// codes 1 and 3 are not named but also give two stop bits
	typedef enum logic [1:0] {
		STOP_1 = 2'd0,
		STOP_2 = 2'd2
	} uart_stop_bits_e;

	typedef enum logic [1:0] {
		PAR_ODD   = 2'd0,
		PAR_EVEN  = 2'd1,
		PAR_MARK  = 2'd2,
		PAR_SPACE = 2'd3
	} uart_parity_e;

	typedef struct packed {
		logic [`UART_BAUD_DIV_W-1:0] baud_div;  // 10M/8/baudrate - 1
		uart_data_bits_e data_bits;
		uart_stop_bits_e stop_bits;
		logic parity_en;
		uart_parity_e parity;
	} uart_cfg_t;

	typedef struct packed {
		logic [7:0] data;  // right aligned, unused upper bits zero
		logic parity_err;
		logic frame_err;
	} uart_rx_word_t;

	typedef enum logic [3:0] {
		TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP0, TX_STOP1, TX_DONE
	} uart_tx_state_e;

	typedef enum logic [3:0] {
		RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP
	} uart_rx_state_e;

	// index of the last data bit for a width code
	function automatic logic [2:0] uart_last_bit(uart_data_bits_e bits);
		return 3'd7 - {1'b0, bits};
	endfunction

	// parity bit for the active data width, used by both directions
	function automatic logic uart_parity_bit(logic [7:0] data, uart_data_bits_e bits,
			uart_parity_e mode);
		logic [7:0] active;
		active = data & (8'hff >> bits);
		case (mode)
			PAR_ODD:  return ~(^active);
			PAR_EVEN: return ^active;
			PAR_MARK: return 1'b1;
			default:  return 1'b0;
		endcase
	endfunction

endpackage

`default_nettype wire

/* logic/uart_baud_timer.sv */
`timescale 1ns/100ps
`default_nettype none
`include "uart_defines.svh"

module uart_baud_timer (
	input wire clk,
	input wire rst,
	input wire run,
	input wire [`UART_BAUD_DIV_W-1:0] baud_div,
	output logic mid_tick,
	output logic bit_done
);

	localparam int CLK_DIV = `UART_CLK_MHZ / 10;  // cycles per 100 ns step
	localparam int CLK_DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam int SAMPLE_W = $clog2(`UART_OVERSAMPLE);

	logic [CLK_DIV_W-1:0] clk_cnt;
	logic [`UART_BAUD_DIV_W-1:0] baud_cnt;
	logic [SAMPLE_W-1:0] sample_cnt;
	logic clk_last;
	logic baud_last;
	logic sample_last;

	assign clk_last = clk_cnt == CLK_DIV_W'(CLK_DIV - 1);
	assign baud_last = baud_cnt == baud_div;
	assign sample_last = sample_cnt == SAMPLE_W'(`UART_OVERSAMPLE - 1);

	always_ff @(posedge clk) begin
		if (rst || !run) begin
			clk_cnt <= '0;
			baud_cnt <= '0;
			sample_cnt <= '0;
		end else if (clk_last) begin
			clk_cnt <= '0;
			if (baud_last) begin
				baud_cnt <= '0;
				sample_cnt <= sample_last ? '0 : sample_cnt + 1'b1;  // wraps each bit
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// first cycle of the middle sample, T/2 cycles into the bit
	assign mid_tick = run && sample_cnt == SAMPLE_W'(`UART_OVERSAMPLE / 2) &&
		clk_cnt == '0 && baud_cnt == '0;

	// last cycle of the bit, so a state change lands exactly on the bit edge
	assign bit_done = run && clk_last && baud_last && sample_last;

endmodule

`default_nettype wire

/* logic/uart_tx.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
	input wire clk,
	input wire rst,
	input wire uart_pkg::uart_cfg_t cfg,
	input wire start,
	input wire [7:0] data,
	output logic busy,
	output logic ack,
	output logic tx
);

	import uart_pkg::*;

	uart_tx_state_e state_q;
	uart_tx_state_e state_d;
	logic [7:0] shift_q;
	logic [2:0] bit_cnt;
	logic par_q;
	logic bit_done;

	uart_baud_timer u_timer (
		.clk(clk),
		.rst(rst),
		.run(busy),  // timer only counts during a frame
		.baud_div(cfg.baud_div),
		.mid_tick(),
		.bit_done(bit_done)
	);

	assign busy = state_q != TX_IDLE;
	assign ack = state_q == TX_DONE;  // one cycle, busy drops right after

	always_comb begin
		state_d = state_q;
		case (state_q)
			TX_IDLE: begin
				if (start)
					state_d = TX_START;
			end
			TX_START: begin
				if (bit_done)
					state_d = TX_DATA;
			end
			TX_DATA: begin
				// narrower widths leave early
				if (bit_done && bit_cnt == uart_last_bit(cfg.data_bits))
					state_d = cfg.parity_en ? TX_PARITY : TX_STOP0;
			end
			TX_PARITY: begin
				if (bit_done)
					state_d = TX_STOP0;
			end
			TX_STOP0: begin
				if (bit_done)
					state_d = (cfg.stop_bits == STOP_1) ? TX_DONE : TX_STOP1;
			end
			TX_STOP1: begin
				if (bit_done)
					state_d = TX_DONE;
			end
			TX_DONE: begin
				state_d = TX_IDLE;
			end
			default: begin
				state_d = TX_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= TX_IDLE;
			bit_cnt <= '0;
		end else begin
			state_q <= state_d;
			if (state_q == TX_START)
				bit_cnt <= '0;
			else if (state_q == TX_DATA && bit_done)
				bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// data and parity are captured with the start strobe
	always_ff @(posedge clk) begin
		if (state_q == TX_IDLE && start) begin
			shift_q <= data;
			par_q <= uart_parity_bit(data, cfg.data_bits, cfg.parity);
		end else if (state_q == TX_DATA && bit_done) begin
			shift_q <= {1'b1, shift_q[7:1]};  // lsb first
		end
	end

	// registered line driver, one cycle behind the state
	always_ff @(posedge clk) begin
		if (rst) begin
			tx <= 1'b1;
		end else begin
			case (state_q)
				TX_START:  tx <= 1'b0;
				TX_DATA:   tx <= shift_q[0];
				TX_PARITY: tx <= par_q;
				default:   tx <= 1'b1;  // stop bits and idle
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/uart_rx.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_rx (
	input wire clk,
	input wire rst,
	input wire uart_pkg::uart_cfg_t cfg,
	input wire rx,
	output logic valid,
	output uart_pkg::uart_rx_word_t word
);

	import uart_pkg::*;

	uart_rx_state_e state_q;
	uart_rx_state_e state_d;
	logic [1:0] sync_q;
	logic rx_s;
	logic rx_prev;
	logic [7:0] shift_q;
	logic [7:0] data_al;
	logic [2:0] bit_cnt;
	logic par_q;
	logic run;
	logic mid_tick;
	logic bit_done;

	uart_baud_timer u_timer (
		.clk(clk),
		.rst(rst),
		.run(run),
		.baud_div(cfg.baud_div),
		.mid_tick(mid_tick),
		.bit_done(bit_done)
	);

	assign run = state_q != RX_IDLE;
	assign rx_s = sync_q[1];
	assign data_al = shift_q >> cfg.data_bits;  // bits arrive from the top

	always_comb begin
		state_d = state_q;
		case (state_q)
			RX_IDLE: begin
				if (rx_prev && !rx_s)  // falling edge
					state_d = RX_START;
			end
			RX_START: begin
				if (mid_tick && rx_s)  // line back high, glitch
					state_d = RX_IDLE;
				else if (bit_done)
					state_d = RX_DATA;
			end
			RX_DATA: begin
				if (bit_done && bit_cnt == uart_last_bit(cfg.data_bits))
					state_d = cfg.parity_en ? RX_PARITY : RX_STOP;
			end
			RX_PARITY: begin
				if (bit_done)
					state_d = RX_STOP;
			end
			RX_STOP: begin
				if (mid_tick)  // second stop bit is never checked
					state_d = RX_IDLE;
			end
			default: begin
				state_d = RX_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sync_q <= 2'b11;  // line idles high
			rx_prev <= 1'b1;
			state_q <= RX_IDLE;
			bit_cnt <= '0;
			valid <= 1'b0;
		end else begin
			sync_q <= {sync_q[0], rx};
			rx_prev <= rx_s;
			state_q <= state_d;
			if (state_q == RX_START)
				bit_cnt <= '0;
			else if (state_q == RX_DATA && bit_done)
				bit_cnt <= bit_cnt + 1'b1;
			valid <= state_q == RX_STOP && mid_tick;
		end
	end

	always_ff @(posedge clk) begin
		if (mid_tick) begin
			if (state_q == RX_DATA)
				shift_q <= {rx_s, shift_q[7:1]};
			if (state_q == RX_PARITY)
				par_q <= rx_s;
		end
	end

	// result is taken at the middle of the first stop bit
	always_ff @(posedge clk) begin
		if (state_q == RX_STOP && mid_tick) begin
			word.data <= data_al;
			word.parity_err <= cfg.parity_en &&
				(par_q != uart_parity_bit(data_al, cfg.data_bits, cfg.parity));
			word.frame_err <= !rx_s;
		end
	end

endmodule

`default_nettype wire

/* logic/uart_core.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_core (
	input wire clk,
	input wire rst,
	input wire uart_pkg::uart_cfg_t cfg,  // held stable during a frame
	input wire tx_start,
	input wire [7:0] tx_data,
	output logic tx_busy,
	output logic tx_ack,
	output logic tx,
	input wire rx,
	output logic rx_valid,
	output uart_pkg::uart_rx_word_t rx_word
);

	// both directions share the frame settings
	uart_tx u_tx (
		.clk(clk),
		.rst(rst),
		.cfg(cfg),
		.start(tx_start),  // ignored while busy
		.data(tx_data),
		.busy(tx_busy),
		.ack(tx_ack),
		.tx(tx)
	);

	uart_rx u_rx (
		.clk(clk),
		.rst(rst),
		.cfg(cfg),
		.rx(rx),
		.valid(rx_valid),
		.word(rx_word)
	);

endmodule

`default_nettype wire

/* verif/uart_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_properties #(
	parameter bit HAS_BUSY = 1'b1  // cleared where there is no busy flag and no line
) (
	input wire clk,
	input wire rst,
	input wire strobe,  // tx ack or rx valid
	input wire busy,
	input wire line
);

	int fails = 0;  // failed assertions so far

	strobe_one_cycle: assert property (@(posedge clk) disable iff (rst) strobe |=> !strobe)
		else begin
			fails++;
			$error("strobe stayed high for more than one cycle");
		end

	if (HAS_BUSY) begin : g_busy
		line_idle_high: assert property (@(posedge clk) disable iff (rst) !busy |-> line)
			else begin
				fails++;
				$error("serial line low while the transmitter is idle");
			end

		busy_after_strobe: assert property (@(posedge clk) disable iff (rst)
				$fell(busy) |-> $past(strobe))
			else begin
				fails++;
				$error("busy dropped without an ack in the cycle before");
			end
	end

endmodule

bind uart_tx uart_properties u_tx_props (
	.clk(clk), .rst(rst), .strobe(ack), .busy(busy), .line(tx)
);

// the receiver has no busy flag, so only the strobe rule applies
bind uart_rx uart_properties #(.HAS_BUSY(1'b0)) u_rx_props (
	.clk(clk), .rst(rst), .strobe(valid), .busy(1'b0), .line(1'b1)
);

`default_nettype wire

/* verif/uart_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "uart_defines.svh"

module uart_tb;

	import uart_pkg::*;

	localparam int MAX_TESTS = 64;
	localparam int CLK_DIV = `UART_CLK_MHZ / 10;

	logic clk = 1'b0;
	logic rst;
	uart_cfg_t cfg;
	logic tx_start;
	logic [7:0] tx_data;
	logic tx_busy;
	logic tx_ack;
	logic tx;
	logic rx_line;
	logic rx_bang;  // bit-banged line for mode 1
	logic loop_mode;
	logic rx_valid;
	uart_rx_word_t rx_word;
	uart_rx_word_t last_word;

	uart_cfg_t test_cfg [MAX_TESTS];
	uart_rx_word_t test_exp [MAX_TESTS];
	logic [7:0] test_data [MAX_TESTS];
	logic test_mode [MAX_TESTS];
	int num_tests = 0;
	int ack_cnt = 0;
	int rx_cnt = 0;
	int ack_exp = 0;
	int rx_exp = 0;
	int cycles = 0;
	int cycle_limit = 0;
	int err_rx = 0;
	int err_tx = 0;
	int err_other = 0;

	uart_core u_uart_core (
		.clk(clk), .rst(rst), .cfg(cfg), .tx_start(tx_start), .tx_data(tx_data),
		.tx_busy(tx_busy), .tx_ack(tx_ack), .tx(tx), .rx(rx_line),
		.rx_valid(rx_valid), .rx_word(rx_word)
	);

	always #20 clk = ~clk;

	assign rx_line = loop_mode ? tx : rx_bang;

	always @(negedge clk) begin
		if (tx_ack)
			ack_cnt <= ack_cnt + 1;
		if (rx_valid) begin
			rx_cnt <= rx_cnt + 1;
			last_word <= rx_word;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("the run timed out after %0d cycles before all tests finished", cycles);
			$display("test failed");
			$finish;
		end
	end

	function automatic int bit_cycles(input uart_cfg_t c);
		return CLK_DIV * (int'(c.baud_div) + 1) * `UART_OVERSAMPLE;
	endfunction

	// odd adds a one when the count of ones is even, even when it is odd
	function automatic logic parity_rule(input logic [7:0] d, input int n, input uart_parity_e m);
		int ones;
		ones = 0;
		for (int i = 0; i < n; i++)
			if (d[i])
				ones++;
		case (m)
			PAR_ODD:  return (ones % 2) == 0;
			PAR_EVEN: return (ones % 2) == 1;
			PAR_MARK: return 1'b1;
			default:  return 1'b0;
		endcase
	endfunction

	// line order, start first, bits above len stay high
	task automatic build_frame(input uart_cfg_t c, input logic [7:0] d,
			output logic [11:0] frame, output int len);
		int n;
		n = 8 - int'(c.data_bits);
		frame = '1;
		frame[0] = 1'b0;
		for (int i = 0; i < n; i++)
			frame[1 + i] = d[i];
		len = 1 + n;
		if (c.parity_en) begin
			frame[len] = parity_rule(d, n, c.parity);
			len++;
		end
		len = len + ((c.stop_bits == STOP_1) ? 1 : 2);
	endtask

	task automatic sample_tx_frame(input int t, input int len, output logic [11:0] frame);
		frame = '1;
		while (tx !== 1'b0)
			@(negedge clk);
		repeat (t / 2) @(negedge clk);  // middle of the start bit
		for (int i = 0; i < len; i++) begin
			if (i > 0)
				repeat (t) @(negedge clk);
			frame[i] = tx;
		end
	endtask

	task automatic drive_rx_bit(input logic b, input int t);
		rx_bang = b;
		repeat (t) @(posedge clk);
		#1;
	endtask

	task automatic send_rx_frame(input uart_cfg_t c, input logic [7:0] d,
			input uart_rx_word_t exp, input int t);
		int n;
		n = 8 - int'(c.data_bits);
		drive_rx_bit(1'b0, t);
		for (int i = 0; i < n; i++)
			drive_rx_bit(d[i], t);
		if (c.parity_en)
			drive_rx_bit(parity_rule(d, n, c.parity) ^ exp.parity_err, t);
		drive_rx_bit(~exp.frame_err, t);
		if (c.stop_bits != STOP_1)
			drive_rx_bit(1'b1, t);
		rx_bang = 1'b1;
	endtask

	task automatic check_rx(input uart_rx_word_t got, input uart_rx_word_t exp, input int idx);
		if (got !== exp) begin
			err_rx++;
			$display("error at %0t: test %0d rx word %h/%b/%b, expected %h/%b/%b", $time, idx,
				got.data, got.parity_err, got.frame_err, exp.data, exp.parity_err, exp.frame_err);
		end
	endtask

	task automatic check_tx_frame(input logic [11:0] got, input logic [11:0] exp,
			input int len, input int idx);
		logic [11:0] mask;
		mask = 12'hfff >> (12 - len);
		if ((got & mask) !== (exp & mask)) begin
			err_tx++;
			$display("error at %0t: test %0d tx frame %b, expected %b", $time, idx, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what, input int idx);
		if (got !== exp) begin
			err_other++;
			$display("error at %0t: test %0d %s is %b, expected %b", $time, idx, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what, input int idx);
		if (got != exp) begin
			err_other++;
			$display("error at %0t: test %0d %s is %0d, expected %0d", $time, idx, what, got, exp);
		end
	endtask

	task automatic run_test(input int idx);
		uart_cfg_t c;
		int t;
		int len;
		int wait_cnt;
		logic [11:0] got_frame;
		logic [11:0] exp_frame;
		c = test_cfg[idx];
		t = bit_cycles(c);
		@(posedge clk);
		#1;
		cfg = c;
		loop_mode = ~test_mode[idx];
		if (!test_mode[idx]) begin
			tx_start = 1'b1;
			tx_data = test_data[idx];
			@(posedge clk);
			#1;
			check_flag(tx_busy, 1'b1, "tx_busy after the accepted start", idx);
			tx_data = ~test_data[idx];  // second strobe lands while busy
			@(posedge clk);
			#1;
			tx_start = 1'b0;
			ack_exp++;
			rx_exp++;
			build_frame(c, test_data[idx], exp_frame, len);
			sample_tx_frame(t, len, got_frame);
			check_tx_frame(got_frame, exp_frame, len, idx);
			// ack ends the last stop bit, under a bit time after its middle
			wait_cnt = 0;
			while (ack_cnt < ack_exp && wait_cnt < t) begin
				@(negedge clk);
				wait_cnt++;
			end
			check_count(ack_cnt, ack_exp, "tx_ack count at the end of the frame", idx);
			while (ack_cnt < ack_exp || rx_cnt < rx_exp)
				@(negedge clk);
			while (tx_busy)
				@(negedge clk);
		end else begin
			rx_exp++;
			send_rx_frame(c, test_data[idx], test_exp[idx], t);
			while (rx_cnt < rx_exp)
				@(negedge clk);
			repeat (t / 2) @(negedge clk);
		end
		repeat (4) @(negedge clk);
		check_count(ack_cnt, ack_exp, "tx_ack count", idx);
		check_count(rx_cnt, rx_exp, "rx_valid count", idx);
		check_rx(last_word, test_exp[idx], idx);
	endtask

	initial begin
		int fd;
		int f_mode;
		int f_bd;
		int f_db;
		int f_sb;
		int f_pe;
		int f_par;
		int f_data;
		int f_exp;
		int f_perr;
		int f_ferr;
		int max_t;
		int errors;
		rst = 1'b1;
		cfg = '0;
		tx_start = 1'b0;
		tx_data = 8'h00;
		rx_bang = 1'b1;
		loop_mode = 1'b1;
		max_t = 0;
		fd = $fopen("verif/uart_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open verif/uart_tests.txt, so no tests were run");
			err_other++;
		end else begin
			while (num_tests < MAX_TESTS && $fscanf(fd, "%d %d %d %d %d %d %h %h %d %d",
					f_mode, f_bd, f_db, f_sb, f_pe, f_par, f_data, f_exp, f_perr, f_ferr) == 10) begin
				test_mode[num_tests] = f_mode != 0;
				test_cfg[num_tests] = {8'(f_bd), 2'(f_db), 2'(f_sb), 1'(f_pe), 2'(f_par)};
				test_data[num_tests] = 8'(f_data);
				test_exp[num_tests] = {8'(f_exp), 1'(f_perr), 1'(f_ferr)};
				if (bit_cycles(test_cfg[num_tests]) > max_t)
					max_t = bit_cycles(test_cfg[num_tests]);
				num_tests++;
			end
			$fclose(fd);
			if (num_tests == 0) begin
				$display("the test file held no readable test lines");
				err_other++;
			end
		end
		cycle_limit = (num_tests + 2) * 13 * max_t;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int i = 0; i < num_tests; i++)
			run_test(i);
		errors = err_rx + err_tx + err_other + u_uart_core.u_tx.u_tx_props.fails +
			u_uart_core.u_rx.u_rx_props.fails;
		$display("errors: %0d (rx word %0d, tx frame %0d, other %0d, assertions %0d)", errors,
			err_rx, err_tx, err_other,
			u_uart_core.u_tx.u_tx_props.fails + u_uart_core.u_rx.u_rx_props.fails);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/uart_tests.txt */
0 0 0 0 0 0 55 55 0 0
0 0 0 0 0 0 a3 a3 0 0
0 1 0 0 0 0 00 00 0 0
0 1 0 0 0 0 ff ff 0 0
0 3 0 0 0 0 81 81 0 0
0 0 1 0 0 0 d5 55 0 0
0 1 2 0 0 0 f3 33 0 0
0 0 3 0 0 0 ee 0e 0 0
0 2 3 0 1 1 b7 17 0 0
0 0 0 0 1 0 5a 5a 0 0
0 0 0 0 1 1 5b 5b 0 0
0 1 0 0 1 2 3c 3c 0 0
0 1 1 0 1 3 c4 44 0 0
0 0 0 2 0 0 96 96 0 0
0 1 2 1 1 1 29 29 0 0
0 0 1 3 1 0 7e 7e 0 0
1 0 0 0 1 1 6d 6d 1 0
1 0 0 0 0 0 42 42 0 1
1 1 3 2 1 0 13 13 1 1
1 0 0 0 1 0 c8 c8 0 0

/* verilog.f */
+incdir+logic
logic/uart_pkg.sv
logic/uart_baud_timer.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_core.sv
verif/uart_properties.sv
verif/uart_tb.sv

/* run.sh */
#!/bin/sh
# compile with Verilator and run the UART testbench from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module uart_tb -Mdir obj_dir

out=$(./obj_dir/Vuart_tb +verilator+error+limit+1000)
echo "$out"

if echo "$out" | grep -qx "test passed"; then
	exit 0
fi
exit 1
